/* source/spi_consts.svh */
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// axi4-lite bus widths
`define SPI_DW          32
`define SPI_AW          5

// rx fifo geometry
`define SPI_FIFO_DEPTH  8
`define SPI_FIFO_PW     3     // pointer width
`define SPI_FIFO_CW     4     // count width, holds 0..depth

// payload
`define SPI_MAX_PSIZE   4     // bytes after the command byte
`define SPI_PSIZE_W     3

// register map, byte offsets
`define SPI_ADDR_CONFIG 5'h00 // en, cpol, cpha
`define SPI_ADDR_CLKDIV 5'h04
`define SPI_ADDR_PSIZE  5'h08
`define SPI_ADDR_CMD    5'h0C
`define SPI_ADDR_TXDATA 5'h10 // write kicks off a transfer
`define SPI_ADDR_STATUS 5'h14 // read only
`define SPI_ADDR_RXDATA 5'h18 // read pops fifo

`endif

/* source/spi_pkg.sv */
`include "spi_consts.svh"

package spi_pkg;

   // engine states, one baud period granularity
   typedef enum logic [2:0] {
      IDLE   = 3'd0,  // ss high
      SETUP  = 3'd1,  // ss low, shifter loaded
      CMD    = 3'd2,  // command byte
      DATA   = 3'd3,  // payload bytes
      FINISH = 3'd4   // hold ss low one more period
   } spi_state_t;

   // register offsets as seen on awaddr/araddr
   typedef enum logic [`SPI_AW-1:0] {
      REG_CONFIG = `SPI_ADDR_CONFIG,
      REG_CLKDIV = `SPI_ADDR_CLKDIV,
      REG_PSIZE  = `SPI_ADDR_PSIZE,
      REG_CMD    = `SPI_ADDR_CMD,
      REG_TXDATA = `SPI_ADDR_TXDATA,
      REG_STATUS = `SPI_ADDR_STATUS,
      REG_RXDATA = `SPI_ADDR_RXDATA
   } spi_reg_t;

   // axi response codes, exokay/decerr never issued
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_t;

endpackage

/* source/spi_cfg_if.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

// configuration bundle from the register block to the spi engine
interface spi_cfg_if;

   logic                    en;       // peripheral enable
   logic                    cpol;     // idle level of sclk
   logic                    cpha;     // 1 = sample on trailing edge
   logic [7:0]              clkdiv;   // baud period = clkdiv+1 clocks
   logic [`SPI_PSIZE_W-1:0] psize;    // payload bytes after cmd
   logic [7:0]              cmd;      // command byte, sent first
   logic [`SPI_DW-1:0]      tx_data;  // payload, msb byte first
   logic                    start;    // one cycle kick
   logic                    busy;     // engine out of idle

   //########################################
   // register side
   //########################################
   modport regs (
      output en, cpol, cpha, clkdiv, psize, cmd, tx_data, start,
      input  busy
   );

   //########################################
   // engine side, en is gated in the regs
   //########################################
   modport engine (
      input  cpol, cpha, clkdiv, psize, cmd, tx_data, start,
      output busy
   );

endinterface

/* source/spi_regs.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_regs (
   input  logic                     clk,
   input  logic                     nreset,
   // write address / data / response channels
   input  logic [`SPI_AW-1:0]       awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  logic [`SPI_DW-1:0]       wdata,
   input  logic                     wvalid,
   output logic                     wready,
   output spi_pkg::axi_resp_t       bresp,
   output logic                     bvalid,
   input  logic                     bready,
   // read address / data channels
   input  logic [`SPI_AW-1:0]       araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output logic [`SPI_DW-1:0]       rdata,
   output spi_pkg::axi_resp_t       rresp,
   output logic                     rvalid,
   input  logic                     rready,
   // engine config
   spi_cfg_if.regs                  cfg,
   // rx fifo
   input  logic [7:0]               rd_byte,
   input  logic                     rx_empty,
   input  logic [`SPI_FIFO_CW-1:0]  rx_count,
   output logic                     pop
);
   import spi_pkg::*;

   spi_reg_t           wr_reg;
   spi_reg_t           rd_reg;
   logic               wr_fire;  // aw/w handshake edge
   logic               wr_err;
   logic               wr_ok;
   logic               rd_fire;  // ar handshake edge
   logic               rd_err;
   logic [`SPI_DW-1:0] rd_word;

   //########################################
   // write channel
   //########################################
   assign wr_reg  = spi_reg_t'(awaddr);
   assign wr_fire = awvalid && awready;  // wvalid is held alongside
   assign wready  = awready;             // both readies pulse together
   assign wr_ok   = wr_fire && !wr_err;

   always_comb begin
      wr_err = 1'b0;
      case (wr_reg)
         REG_CONFIG, REG_CLKDIV, REG_PSIZE, REG_CMD: wr_err = 1'b0;
         REG_TXDATA: wr_err = cfg.busy || cfg.start || !cfg.en;  // no kick mid transfer
         default:    wr_err = 1'b1;  // status, rxdata, holes
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         awready <= 1'b0;
         bvalid  <= 1'b0;
         bresp   <= OKAY;
      end else begin
         // one cycle pulse, stalled while a response is pending
         awready <= awvalid && wvalid && !bvalid && !awready;
         if (wr_fire) begin
            bvalid <= 1'b1;
            bresp  <= wr_err ? SLVERR : OKAY;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // control bits
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cfg.en     <= 1'b0;
         cfg.cpol   <= 1'b0;
         cfg.cpha   <= 1'b0;
         cfg.clkdiv <= '0;
         cfg.psize  <= '0;
         cfg.start  <= 1'b0;
      end else begin
         cfg.start <= wr_ok && (wr_reg == REG_TXDATA);
         if (wr_ok) begin
            case (wr_reg)
               REG_CONFIG: begin
                  cfg.en   <= wdata[0];
                  cfg.cpol <= wdata[1];
                  cfg.cpha <= wdata[2];
               end
               REG_CLKDIV: cfg.clkdiv <= wdata[7:0];
               REG_PSIZE:  cfg.psize  <= wdata[`SPI_PSIZE_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // data bytes for the shifter
   always_ff @(posedge clk) begin
      if (wr_ok && (wr_reg == REG_CMD))
         cfg.cmd <= wdata[7:0];
      if (wr_ok && (wr_reg == REG_TXDATA))
         cfg.tx_data <= wdata;  // same edge as start
   end

   //########################################
   // read channel
   //########################################
   assign rd_reg  = spi_reg_t'(araddr);
   assign rd_fire = arvalid && arready;
   assign pop     = rd_fire && (rd_reg == REG_RXDATA) && !rx_empty;

   always_comb begin
      rd_err  = 1'b0;
      rd_word = '0;
      case (rd_reg)
         REG_CONFIG: rd_word[2:0] = {cfg.cpha, cfg.cpol, cfg.en};
         REG_CLKDIV: rd_word[7:0] = cfg.clkdiv;
         REG_PSIZE:  rd_word[`SPI_PSIZE_W-1:0] = cfg.psize;
         REG_CMD:    rd_word[7:0] = cfg.cmd;
         REG_TXDATA: rd_word = cfg.tx_data;
         REG_STATUS: rd_word[7:0] = {rx_count, 2'b00, rx_empty, cfg.busy};
         REG_RXDATA: rd_word[7:0] = rx_empty ? 8'h00 : rd_byte;  // head of fifo
         default:    rd_err = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rresp   <= OKAY;
      end else begin
         arready <= arvalid && !rvalid && !arready;
         if (rd_fire) begin
            rvalid <= 1'b1;
            rresp  <= rd_err ? SLVERR : OKAY;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
      if (rd_fire)
         rdata <= rd_word;  // latched at address handshake

endmodule

/* source/spi_master_io.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master_io (
   input  logic        clk,
   input  logic        nreset,
   spi_cfg_if.engine   cfg,
   // spi pins
   output logic        sclk,
   output logic        mosi,
   output logic        ss,
   input  logic        miso,
   // received bytes
   output logic [7:0]  rx_byte,
   output logic        rx_valid
);
   import spi_pkg::*;

   localparam int SH_W = 8 + `SPI_DW;          // cmd byte plus full payload
   localparam int BC_W = `SPI_PSIZE_W + 3;     // bit index within transfer

   spi_state_t              state;
   logic [7:0]              baud_cnt;
   logic                    baud_match;
   logic                    ph;        // half bit phase, 1 = past leading edge
   logic                    shifting;
   logic                    lead;
   logic                    trail;
   logic                    sample;
   logic                    drive;
   logic [BC_W-1:0]         bit_cnt;
   logic [`SPI_PSIZE_W-1:0] psize_eff;
   logic                    last_bit;
   logic [SH_W-1:0]         tx_sh;
   logic [6:0]              rx_sh;

   //########################################
   // baud counter
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         baud_cnt <= '0;
      else if (cfg.start || baud_match)
         baud_cnt <= '0;  // realign to the transfer
      else
         baud_cnt <= baud_cnt + 8'd1;
   end

   assign baud_match = (baud_cnt == cfg.clkdiv);

   //########################################
   // state machine
   //########################################
   // clamp oversize payload requests
   assign psize_eff = (cfg.psize > `SPI_PSIZE_W'(`SPI_MAX_PSIZE)) ?
                      `SPI_PSIZE_W'(`SPI_MAX_PSIZE) : cfg.psize;
   assign last_bit  = (bit_cnt == {psize_eff, 3'b111});

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:   if (cfg.start) state <= SETUP;
            SETUP:  if (baud_match) state <= CMD;
            CMD:
               if (trail && (bit_cnt[2:0] == 3'd7))
                  state <= (psize_eff == '0) ? FINISH : DATA;
            DATA:   if (trail && last_bit) state <= FINISH;
            FINISH: if (baud_match) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   assign cfg.busy = (state != IDLE);
   assign ss       = (state == IDLE);  // active low select

   //########################################
   // sclk generator
   //########################################
   assign shifting = (state == CMD) || (state == DATA);
   assign lead     = shifting && baud_match && !ph;
   assign trail    = shifting && baud_match && ph;   // also ends a bit
   assign sample   = cfg.cpha ? trail : lead;
   assign drive    = cfg.cpha ? lead : trail;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         ph <= 1'b0;
      else if (cfg.start)
         ph <= 1'b0;
      else if (shifting && baud_match)
         ph <= ~ph;  // two baud periods per bit
   end

   assign sclk = cfg.cpol ^ ph;  // idles at cpol

   // completed bits, counted on trailing edges
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         bit_cnt <= '0;
      else if (cfg.start)
         bit_cnt <= '0;
      else if (trail)
         bit_cnt <= bit_cnt + 1'b1;
   end

   //########################################
   // tx shifter
   //########################################
   // cpha 0 puts the first bit out before the first edge
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         mosi <= 1'b0;
      else if (cfg.start)
         mosi <= cfg.cpha ? 1'b0 : cfg.cmd[7];
      else if (drive)
         mosi <= tx_sh[SH_W-1];
   end

   always_ff @(posedge clk) begin
      if (cfg.start) begin
         if (cfg.cpha)
            tx_sh <= {cfg.cmd, cfg.tx_data};
         else
            tx_sh <= {cfg.cmd[6:0], cfg.tx_data, 1'b0};  // msb already on mosi
      end else if (drive) begin
         tx_sh <= {tx_sh[SH_W-2:0], 1'b0};
      end
   end

   //########################################
   // rx shifter
   //########################################
   always_ff @(posedge clk) begin
      if (sample)
         rx_sh <= {rx_sh[5:0], miso};
      if (sample && (bit_cnt[2:0] == 3'd7))
         rx_byte <= {rx_sh, miso};  // msb first
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         rx_valid <= 1'b0;
      else
         rx_valid <= sample && (bit_cnt[2:0] == 3'd7);  // one pulse per byte
   end

endmodule

/* source/spi_rx_fifo.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_rx_fifo (
   input  logic                     clk,
   input  logic                     nreset,
   // from engine
   input  logic [7:0]               rx_byte,
   input  logic                     rx_valid,
   // to register block
   input  logic                     pop,
   output logic [7:0]               rd_byte,
   output logic                     empty,
   output logic [`SPI_FIFO_CW-1:0]  count
);

   logic [7:0]              mem [`SPI_FIFO_DEPTH];
   logic [`SPI_FIFO_PW-1:0] wr_ptr;
   logic [`SPI_FIFO_PW-1:0] rd_ptr;
   logic                    full;
   logic                    push;
   logic                    do_pop;

   assign full   = (count == `SPI_FIFO_CW'(`SPI_FIFO_DEPTH));
   assign empty  = (count == '0);
   assign push   = rx_valid && !full;  // overflow bytes are lost
   assign do_pop = pop && !empty;

   //########################################
   // storage
   //########################################
   always_ff @(posedge clk)
      if (push)
         mem[wr_ptr] <= rx_byte;

   assign rd_byte = mem[rd_ptr];  // head, valid when !empty

   //########################################
   // pointers and fill count
   //########################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // idle or push+pop
         endcase
      end
   end

endmodule

/* source/spi_master.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master (
   input  logic                clk,
   input  logic                nreset,
   // axi4-lite write
   input  logic [`SPI_AW-1:0]  awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  logic [`SPI_DW-1:0]  wdata,
   input  logic                wvalid,
   output logic                wready,
   output spi_pkg::axi_resp_t  bresp,
   output logic                bvalid,
   input  logic                bready,
   // axi4-lite read
   input  logic [`SPI_AW-1:0]  araddr,
   input  logic                arvalid,
   output logic                arready,
   output logic [`SPI_DW-1:0]  rdata,
   output spi_pkg::axi_resp_t  rresp,
   output logic                rvalid,
   input  logic                rready,
   // spi pins
   output logic                sclk,
   output logic                mosi,
   output logic                ss,
   input  logic                miso
);

   logic [7:0]               rx_byte;
   logic                     rx_valid;
   logic                     pop;
   logic [7:0]               rd_byte;
   logic                     rx_empty;
   logic [`SPI_FIFO_CW-1:0]  rx_count;

   spi_cfg_if cfg ();  // regs -> engine

   // decode
   spi_regs regs0 (
      .clk, .nreset,
      .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .cfg      (cfg.regs),
      .rd_byte, .rx_empty, .rx_count, .pop
   );

   // execute
   spi_master_io io0 (
      .clk, .nreset,
      .cfg      (cfg.engine),
      .sclk, .mosi, .ss, .miso,
      .rx_byte, .rx_valid
   );

   // result
   spi_rx_fifo fifo0 (
      .clk, .nreset,
      .rx_byte, .rx_valid, .pop, .rd_byte,
      .empty    (rx_empty),
      .count    (rx_count)
   );

endmodule

/* dv/spi_slave_model.sv */
`timescale 1ns/1ps

// behavioral spi slave, mode follows cpol/cpha
module spi_slave_model (
   input  logic sclk,
   input  logic mosi,
   input  logic ss,
   input  logic cpol,
   input  logic cpha,
   output logic miso
);

   logic [7:0] mosi_q [$];  // bytes seen on mosi
   logic [7:0] miso_q [$];  // bytes to send back
   logic [7:0] rx_sh;
   logic [7:0] tx_sh;
   int         rx_bits;
   int         tx_bits;

   initial begin
      miso    = 1'b0;
      rx_sh   = '0;
      tx_sh   = '0;
      rx_bits = 0;
      tx_bits = 0;
   end

   // next miso bit, refill at byte boundaries
   task automatic shift_out();
      if (tx_bits == 0) begin
         if (miso_q.size() > 0)
            tx_sh = miso_q.pop_front();
         else
            tx_sh = 8'h00;  // queue ran dry
      end
      miso    = tx_sh[7];
      tx_sh   = {tx_sh[6:0], 1'b0};
      tx_bits = (tx_bits + 1) % 8;
   endtask

   always @(negedge ss) begin
      rx_bits = 0;
      tx_bits = 0;
      if (!cpha)
         shift_out();  // first bit ahead of the first edge
   end

   // leading edge leaves the idle level
   always @(sclk) begin
      if (!ss) begin
         if ((sclk != cpol) ^ cpha) begin  // sample edge
            rx_sh   = {rx_sh[6:0], mosi};
            rx_bits = rx_bits + 1;
            if (rx_bits == 8) begin
               mosi_q.push_back(rx_sh);
               rx_bits = 0;
            end
         end else begin
            shift_out();
         end
      end
   end

endmodule

/* dv/tb_spi_master.sv */
`timescale 1ns/1ps
`include "spi_consts.svh"

module tb_spi_master;
   import spi_pkg::*;

   logic               clk;
   logic               nreset;
   logic [`SPI_AW-1:0] awaddr;
   logic               awvalid;
   logic               awready;
   logic [`SPI_DW-1:0] wdata;
   logic               wvalid;
   logic               wready;
   axi_resp_t          bresp;
   logic               bvalid;
   logic               bready;
   logic [`SPI_AW-1:0] araddr;
   logic               arvalid;
   logic               arready;
   logic [`SPI_DW-1:0] rdata;
   axi_resp_t          rresp;
   logic               rvalid;
   logic               rready;
   logic               sclk;
   logic               mosi;
   logic               ss;
   logic               miso;
   logic               mode_cpol;  // mode the slave follows
   logic               mode_cpha;
   logic [31:0]        lfsr;
   logic [7:0]         exp_rx [$];  // slave bytes in send order
   int                 errors;
   int                 checks;

   spi_master dut0 (.*);

   spi_slave_model slave0 (
      .sclk, .mosi, .ss, .miso,
      .cpol (mode_cpol),
      .cpha (mode_cpha)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // sclk rests at cpol while the slave is deselected
   always @(posedge clk) begin
      if (nreset === 1'b1 && ss === 1'b1 && sclk !== mode_cpol) begin
         errors++;
         $display("sclk left its idle level %b while ss was high", mode_cpol);
      end
   end

   // fibonacci lfsr on taps 32 22 2 1
   function automatic logic [7:0] next_byte();
      logic [7:0] b;
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // one step per bit
         b    = {b[6:0], lfsr[0]};
      end
      return b;
   endfunction

   // worst case clocks for one transfer incl. register traffic
   function automatic int xfer_cycles(input int div, input int nbytes);
      return (div + 1) * (2 + 16 * nbytes) + 150;
   endfunction

   //########################################
   // compare tasks
   //########################################
   task automatic cmp_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic cmp_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic cmp_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   //########################################
   // axi4-lite access
   //########################################
   task automatic axi_write(input logic [`SPI_AW-1:0] addr, input logic [31:0] data,
                            output axi_resp_t resp);
      int n;
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      n = 0;
      while (!(awready && wready) && n < 50) begin
         @(negedge clk);
         n++;
      end
      @(negedge clk);  // handshake edge passed
      awvalid = 1'b0;
      wvalid  = 1'b0;
      n = 0;
      while (!bvalid && n < 50) begin
         @(negedge clk);
         n++;
      end
      if (!bvalid) begin
         errors++;
         $display("write to offset %h never got a response", addr);
      end
      resp = bresp;  // bvalid drops next edge with bready high
   endtask

   task automatic axi_read(input logic [`SPI_AW-1:0] addr, output logic [31:0] data,
                           output axi_resp_t resp);
      int n;
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      n = 0;
      while (!arready && n < 50) begin
         @(negedge clk);
         n++;
      end
      @(negedge clk);
      arvalid = 1'b0;
      n = 0;
      while (!rvalid && n < 50) begin
         @(negedge clk);
         n++;
      end
      if (!rvalid) begin
         errors++;
         $display("read from offset %h never got data", addr);
      end
      data = rdata;
      resp = rresp;
   endtask

   task automatic write_ok(input logic [`SPI_AW-1:0] addr, input logic [31:0] data);
      axi_resp_t r;
      axi_write(addr, data, r);
      cmp_resp("bresp", r, OKAY);
   endtask

   task automatic read_expect(input logic [`SPI_AW-1:0] addr, input logic [31:0] exp);
      axi_resp_t   r;
      logic [31:0] d;
      axi_read(addr, d, r);
      cmp_word("rdata", d, exp);
      cmp_resp("rresp", r, OKAY);
   endtask

   //########################################
   // transfer helpers
   //########################################
   task automatic set_mode(input logic cpol, input logic cpha, input logic [7:0] div,
                           input logic [2:0] psize, input logic [7:0] cmd);
      write_ok(REG_CONFIG, {29'd0, cpha, cpol, 1'b1});
      mode_cpol = cpol;  // sclk already moved on the handshake edge
      mode_cpha = cpha;
      write_ok(REG_CLKDIV, {24'd0, div});
      write_ok(REG_PSIZE, {29'd0, psize});
      write_ok(REG_CMD, {24'd0, cmd});
   endtask

   // one transfer with an optional kick while busy
   task automatic run_xfer(input logic [7:0] cmd, input logic [31:0] tx, input int psize,
                           input bit kick_busy);
      axi_resp_t   r;
      logic [31:0] st;
      logic [7:0]  b;
      int          n;
      slave0.miso_q.delete();
      slave0.mosi_q.delete();
      for (int i = 0; i <= psize; i++) begin
         b = next_byte();
         slave0.miso_q.push_back(b);
         exp_rx.push_back(b);
      end
      @(negedge clk);
      if (ss !== 1'b1 || sclk !== mode_cpol) begin
         errors++;
         $display("ss or sclk not idle before the transfer");
      end
      write_ok(REG_TXDATA, tx);
      if (kick_busy) begin
         axi_write(REG_TXDATA, ~tx, r);  // must bounce
         cmp_resp("bresp", r, SLVERR);
      end
      n  = 0;
      st = 32'h1;
      while (st[0] && n < 2000) begin
         axi_read(REG_STATUS, st, r);
         n++;
      end
      if (st[0]) begin
         errors++;
         $display("busy never dropped after the transfer");
      end
      if (ss !== 1'b1 || sclk !== mode_cpol) begin
         errors++;
         $display("ss or sclk not idle after busy fell");
      end
      if (slave0.mosi_q.size() != psize + 1) begin
         errors++;
         $display("slave saw %0d mosi bytes, wanted %0d", slave0.mosi_q.size(), psize + 1);
      end else begin
         cmp_byte("mosi", slave0.mosi_q[0], cmd);
         for (int i = 1; i <= psize; i++)
            cmp_byte("mosi", slave0.mosi_q[i], tx[31 - 8 * (i - 1) -: 8]);
      end
   endtask

   // pop n bytes and expect an empty fifo
   task automatic drain_rx(input int n);
      for (int i = 0; i < n; i++)
         read_expect(REG_RXDATA, {24'd0, exp_rx.pop_front()});
      exp_rx.delete();
      read_expect(REG_STATUS, 32'h2);
   endtask

   //########################################
   // tests
   //########################################
   task automatic regs_readback();
      read_expect(REG_STATUS, 32'h2);  // idle and empty
      write_ok(REG_CONFIG, 32'hffff_fff7);
      mode_cpol = 1'b1;
      read_expect(REG_CONFIG, 32'h7);
      write_ok(REG_CLKDIV, 32'h1234_5678);
      read_expect(REG_CLKDIV, 32'h78);
      write_ok(REG_PSIZE, 32'hffff_fffd);
      read_expect(REG_PSIZE, 32'h5);
      write_ok(REG_CMD, 32'hcafe_be9f);
      read_expect(REG_CMD, 32'h9f);
   endtask

   task automatic mode0_xfer();
      set_mode(1'b0, 1'b0, 8'd1, 3'd4, 8'h9e);
      run_xfer(8'h9e, 32'hdead_beef, 4, 1'b0);
   endtask

   task automatic rx_readout();
      drain_rx(5);  // cmd slot plus 4 payload
   endtask

   task automatic mode_sweep();
      set_mode(1'b0, 1'b1, 8'd0, 3'd0, 8'h61);
      run_xfer(8'h61, 32'h0, 0, 1'b0);
      drain_rx(1);
      set_mode(1'b1, 1'b0, 8'd3, 3'd2, 8'ha2);
      run_xfer(8'ha2, 32'h13c8_77e1, 2, 1'b0);
      drain_rx(3);
      set_mode(1'b1, 1'b1, 8'd2, 3'd3, 8'h5b);
      run_xfer(8'h5b, 32'h8f04_d2a6, 3, 1'b0);
      drain_rx(4);
   endtask

   task automatic error_resps();
      axi_resp_t   r;
      logic [31:0] d;
      axi_write(5'h1c, 32'h1, r);  // hole in the map
      cmp_resp("bresp", r, SLVERR);
      read_expect(REG_CONFIG, 32'h7);  // left over from the mode sweep
      read_expect(REG_CLKDIV, 32'h2);
      read_expect(REG_PSIZE, 32'h3);
      read_expect(REG_CMD, 32'h5b);
      read_expect(REG_TXDATA, 32'h8f04_d2a6);
      axi_read(5'h1c, d, r);
      cmp_resp("rresp", r, SLVERR);
      set_mode(1'b0, 1'b0, 8'd7, 3'd1, 8'h3c);
      run_xfer(8'h3c, 32'h5a5a_1234, 1, 1'b1);
      drain_rx(2);
      write_ok(REG_CONFIG, 32'h0);  // disabled
      axi_write(REG_TXDATA, 32'h0bad_f00d, r);
      cmp_resp("bresp", r, SLVERR);
      read_expect(REG_TXDATA, 32'h5a5a_1234);
      read_expect(REG_STATUS, 32'h2);
      if (slave0.mosi_q.size() != 2) begin
         errors++;
         $display("a transfer ran while the peripheral was disabled");
      end
      axi_write(REG_STATUS, 32'hff, r);
      cmp_resp("bresp", r, SLVERR);
      read_expect(REG_STATUS, 32'h2);
   endtask

   task automatic fifo_overflow();
      set_mode(1'b0, 1'b0, 8'd0, 3'd4, 8'hc3);
      for (int i = 0; i < 3; i++)
         run_xfer(8'hc3, 32'h0102_0304 + i, 4, 1'b0);
      read_expect(REG_STATUS, 32'h80);  // full with 8 held
      drain_rx(8);
   endtask

   //########################################
   // watchdog and main sequence
   //########################################
   initial begin : watchdog
      int limit;
      limit = xfer_cycles(1, 5) + xfer_cycles(0, 1) + xfer_cycles(3, 3)
            + xfer_cycles(2, 4) + xfer_cycles(7, 2) + 3 * xfer_cycles(0, 5) + 3000;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d cycles, engine in %s", limit,
               dut0.io0.state.name());
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      nreset    = 1'b0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wvalid    = 1'b0;
      bready    = 1'b1;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b1;
      mode_cpol = 1'b0;
      mode_cpha = 1'b0;
      lfsr      = 32'h48bd32c4;
      errors    = 0;
      checks    = 0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      regs_readback();
      mode0_xfer();
      rx_readout();
      mode_sweep();
      error_resps();
      fifo_overflow();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* spi_master.f */
+incdir+source
source/spi_pkg.sv
source/spi_cfg_if.sv
source/spi_regs.sv
source/spi_master_io.sv
source/spi_rx_fifo.sv
source/spi_master.sv
dv/spi_slave_model.sv
dv/tb_spi_master.sv

/* Makefile */
TOP = tb_spi_master

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f spi_master.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f spi_master.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
